/* list.f */
src/trace_pkg.sv
src/core_trace_monitor.sv
src/event_fifo.sv
src/event_arbiter.sv
src/termination_collector.sv
src/trace_monitor_top.sv
tb/tb_trace_monitor_top.sv

/* run.sh */
#!/bin/sh
# Build and run the trace monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_trace_monitor_top -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

/* tb/tb_trace_monitor_top.sv */
module tb_trace_monitor_top;
   localparam int NUM_CORES = 4;
   localparam int FIFO_DEPTH = 4;
   // Ordinary instruction that is not a no-operation
   localparam logic [31:0] PLAIN_INSN = 32'h9c60_0000;

   logic clk, rst_n;
   trace_pkg::trace_rec_t [NUM_CORES-1:0] trace;
   logic event_valid;
   trace_pkg::mon_event_t event_w;
   logic [NUM_CORES-1:0] overflow, exited;
   logic [NUM_CORES-1:0][31:0] exit_codes;
   logic all_done;
   // Reference copy of each core's r3 and every event seen at the output
   logic [31:0] r3_model [NUM_CORES];
   trace_pkg::mon_event_t got_q[$];
   int errors = 0, tests_run = 0, tests_failed = 0;

   trace_monitor_top #(.NUM_CORES(NUM_CORES), .FIFO_DEPTH(FIFO_DEPTH)) i_trace_monitor_top (
      .clk_i(clk), .rst_n_i(rst_n), .trace_i(trace), .event_valid_o(event_valid),
      .event_o(event_w), .overflow_o(overflow), .exited_o(exited),
      .exit_codes_o(exit_codes), .all_done_o(all_done));

   // Free-running clock of period 20
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Output stream sampled away from the rising edge
   always @(negedge clk) begin
      if (rst_n && event_valid) got_q.push_back(event_w);
   end

   // Expected event built field by field
   function automatic trace_pkg::mon_event_t make_event(int core, trace_pkg::event_kind_e kind,
         logic [31:0] pc, logic [31:0] value);
      trace_pkg::mon_event_t ev;
      ev.core = core[trace_pkg::CORE_ID_W-1:0];
      ev.kind = kind;
      ev.pc = pc;
      ev.value = value;
      return ev;
   endfunction

   // No-operation word with the given immediate
   function automatic logic [31:0] nop_word(logic [15:0] k);
      return {trace_pkg::NOP_OPCODE, 8'h00, k};
   endfunction

   // Inputs change shortly after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // Model follows r3 writes so expected values are taken before the call
   task automatic set_rec(int core, logic [31:0] pc, logic [31:0] insn, logic wben,
         logic [4:0] wbreg, logic [31:0] wbdata);
      trace[core] = '{valid: 1'b1, pc: pc, insn: insn, wben: wben, wbreg: wbreg, wbdata: wbdata};
      if (wben && wbreg == 5'd3) r3_model[core] = wbdata;
   endtask

   // Two cycles of reset with idle trace inputs
   task automatic apply_reset();
      rst_n = 1'b0;
      trace = '0;
      for (int c = 0; c < NUM_CORES; c++) r3_model[c] = '0;
      repeat (2) next_cycle();
      rst_n = 1'b1;
      got_q.delete();
   endtask

   // Waits for a number of output events, bounded by a cycle limit
   task automatic wait_events(string name, int count, int limit);
      int waited;
      waited = 0;
      while (got_q.size() < count && waited < limit) begin
         next_cycle();
         waited++;
      end
      if (got_q.size() < count) begin
         $display("%s: no %0d events within %0d cycles, only %0d", name, count, limit,
                  got_q.size());
         errors++;
      end
   endtask

   task automatic check_event(string name, trace_pkg::mon_event_t exp, trace_pkg::mon_event_t act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flags(string name, logic [NUM_CORES-1:0] exp, logic [NUM_CORES-1:0] act);
      if (act !== exp) begin
         $display("Error %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   // Removes the first queued event of one core to keep per-core order
   task automatic take_event(string name, int core, output trace_pkg::mon_event_t ev);
      ev = '0;
      foreach (got_q[i]) begin
         if (got_q[i].core == core) begin
            ev = got_q[i];
            got_q.delete(i);
            return;
         end
      end
      $display("%s: an event from core %0d never arrived", name, core);
      errors++;
   endtask

   // One summary line per test
   task automatic end_test(string name, int err0);
      tests_run++;
      if (errors == err0) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - err0);
      end
   endtask

   // Core 1 prints one random character
   task automatic putc_event();
      int err0 = errors;
      logic [31:0] pc, ch;
      trace_pkg::mon_event_t exp;
      got_q.delete();
      ch = $urandom & 32'hff;
      pc = $urandom & 32'hffff_fffc;
      set_rec(1, pc - 4, PLAIN_INSN, 1'b1, 5'd3, ch);
      next_cycle();
      exp = make_event(1, trace_pkg::EV_PUTC, pc, r3_model[1]);
      set_rec(1, pc, nop_word(trace_pkg::NOP_K_PUTC), 1'b0, 5'd0, 32'h0);
      next_cycle();
      trace = '0;
      wait_events("putc", 1, 20);
      // Idle window to catch a duplicate
      repeat (6) next_cycle();
      check_word("putc count", 32'd1, got_q.size());
      if (got_q.size() > 0) check_event("putc", exp, got_q[0]);
      end_test("putc", err0);
   endtask

   // Event value is r3 before the record that carries the no-operation
   task automatic old_value_rule();
      int err0 = errors;
      logic [31:0] pc;
      trace_pkg::mon_event_t exp1, exp2;
      got_q.delete();
      pc = $urandom & 32'hffff_fffc;
      set_rec(0, pc, PLAIN_INSN, 1'b1, 5'd3, $urandom);
      next_cycle();
      // Report that also writes r3 sees the value before the write
      exp1 = make_event(0, trace_pkg::EV_REPORT, pc + 4, r3_model[0]);
      set_rec(0, pc + 4, nop_word(trace_pkg::NOP_K_REPORT), 1'b1, 5'd3, $urandom);
      next_cycle();
      exp2 = make_event(0, trace_pkg::EV_REPORT, pc + 8, r3_model[0]);
      set_rec(0, pc + 8, nop_word(trace_pkg::NOP_K_REPORT), 1'b0, 5'd0, 32'h0);
      next_cycle();
      // Unknown immediate and an r4 write are silent
      set_rec(0, pc + 12, nop_word(16'h0003), 1'b0, 5'd0, 32'h0);
      next_cycle();
      set_rec(0, pc + 16, PLAIN_INSN, 1'b1, 5'd4, $urandom);
      next_cycle();
      trace = '0;
      wait_events("old value", 2, 20);
      repeat (6) next_cycle();
      check_word("old value count", 32'd2, got_q.size());
      if (got_q.size() > 1) begin
         check_event("old value first", exp1, got_q[0]);
         check_event("old value second", exp2, got_q[1]);
      end
      end_test("old value", err0);
   endtask

   // All cores report three times in the same cycles
   task automatic merge_four_cores();
      int err0 = errors;
      logic [31:0] pc;
      trace_pkg::mon_event_t exp_q[$];
      trace_pkg::mon_event_t ev;
      got_q.delete();
      for (int n = 0; n < 3; n++) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            pc = $urandom & 32'hffff_fffc;
            exp_q.push_back(make_event(c, trace_pkg::EV_REPORT, pc, r3_model[c]));
            set_rec(c, pc, nop_word(trace_pkg::NOP_K_REPORT), 1'b1, 5'd3, $urandom);
         end
         next_cycle();
      end
      trace = '0;
      wait_events("merge", 3 * NUM_CORES, 40);
      repeat (6) next_cycle();
      check_word("merge count", 3 * NUM_CORES, got_q.size());
      // Each core's events in issue order
      for (int c = 0; c < NUM_CORES; c++) begin
         for (int n = 0; n < 3; n++) begin
            take_event("merge", c, ev);
            check_event("merge order", exp_q[n * NUM_CORES + c], ev);
         end
      end
      check_flags("merge overflow", '0, overflow);
      end_test("merge", err0);
   endtask

   // Burst of six reports from core 2 alone
   task automatic burst_overflow();
      int err0 = errors;
      int j = 0;
      logic [31:0] pc;
      logic [NUM_CORES-1:0] exp_ovf;
      trace_pkg::mon_event_t exp_q[$];
      got_q.delete();
      for (int n = 0; n < 6; n++) begin
         pc = $urandom & 32'hffff_fffc;
         exp_q.push_back(make_event(2, trace_pkg::EV_REPORT, pc, r3_model[2]));
         set_rec(2, pc, nop_word(trace_pkg::NOP_K_REPORT), 1'b1, 5'd3, $urandom);
         next_cycle();
      end
      trace = '0;
      wait_events("overflow", FIFO_DEPTH, 40);
      repeat (8) next_cycle();
      // Received events must be an in-order subset of the issued ones
      foreach (got_q[i]) begin
         while (j < 6 && got_q[i] !== exp_q[j]) j++;
         if (j == 6) begin
            $display("overflow: event %0d is unknown or out of order", i);
            errors++;
            break;
         end
         j++;
      end
      // Flag is expected only when some event was lost
      exp_ovf = '0;
      exp_ovf[2] = got_q.size() < 6;
      check_flags("overflow flag", exp_ovf, overflow);
      end_test("overflow", err0);
   endtask

   // Loads r3 with the code, exits and checks the exit event
   task automatic exit_core(string name, int core, logic [31:0] code);
      logic [31:0] pc;
      got_q.delete();
      pc = $urandom & 32'hffff_fffc;
      set_rec(core, pc, PLAIN_INSN, 1'b1, 5'd3, code);
      next_cycle();
      set_rec(core, pc + 4, nop_word(trace_pkg::NOP_K_EXIT), 1'b0, 5'd0, 32'h0);
      next_cycle();
      trace = '0;
      wait_events(name, 1, 20);
      if (got_q.size() > 0)
         check_event(name, make_event(core, trace_pkg::EV_EXIT, pc + 4, code), got_q[0]);
   endtask

   // Cores exit one at a time with distinct codes
   task automatic exit_sequence();
      int err0 = errors;
      logic [31:0] codes [NUM_CORES];
      logic [NUM_CORES-1:0] exp_exited = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         codes[c] = ($urandom & 32'hffff_ff00) | c;
         exit_core("termination exit", c, codes[c]);
         exp_exited[c] = 1'b1;
         check_flags("termination exited", exp_exited, exited);
         check_word("termination code", codes[c], exit_codes[c]);
         check_word("termination all done", c == NUM_CORES - 1, all_done);
      end
      // Repeated exit keeps the first code
      exit_core("termination second exit", 0, codes[0] ^ 32'h5a5a_0000);
      check_word("termination kept code", codes[0], exit_codes[0]);
      check_word("termination all done kept", 32'd1, all_done);
      end_test("termination", err0);
   endtask

   // Outputs after reset and a reset in the middle of a run
   task automatic reset_clears();
      int err0 = errors;
      apply_reset();
      check_word("reset event valid", 32'd0, event_valid);
      check_flags("reset overflow", '0, overflow);
      check_flags("reset exited", '0, exited);
      check_word("reset all done", 32'd0, all_done);
      for (int c = 0; c < NUM_CORES; c++) check_word("reset code", 32'd0, exit_codes[c]);
      exit_core("reset exit", 3, 32'h0000_0b0b);
      check_flags("reset exited before", 4'b1000, exited);
      apply_reset();
      check_flags("reset exited after", '0, exited);
      end_test("reset", err0);
   endtask

   initial begin
      rst_n = 1'b0;
      trace = '0;
      void'($urandom(32'h22c56629));
      apply_reset();
      putc_event();
      old_value_rule();
      merge_four_cores();
      burst_overflow();
      exit_sequence();
      reset_clears();
      $display("Tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end
endmodule

/* src/trace_monitor_top.sv */
module trace_monitor_top #(
   parameter int NUM_CORES  = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  trace_pkg::trace_rec_t [NUM_CORES-1:0] trace_i,
   output logic                                  event_valid_o,
   output trace_pkg::mon_event_t                 event_o,
   output logic [NUM_CORES-1:0]                  overflow_o,
   output logic [NUM_CORES-1:0]                  exited_o,
   output logic [NUM_CORES-1:0][31:0]            exit_codes_o,
   output logic                                  all_done_o
);

   // Monitor to FIFO
   logic [NUM_CORES-1:0]                  ev_valid;
   trace_pkg::mon_event_t [NUM_CORES-1:0] ev;

   // Monitor to collector
   logic [NUM_CORES-1:0]       exit_strobe;
   logic [NUM_CORES-1:0][31:0] exit_code;

   // FIFO to arbiter and back
   logic [NUM_CORES-1:0]                  fifo_not_empty;
   trace_pkg::mon_event_t [NUM_CORES-1:0] fifo_head;
   logic [NUM_CORES-1:0]                  fifo_pop;

   // One monitor and one FIFO per core
   for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core
      core_trace_monitor #(
         .CORE_ID (c)
      ) u_monitor (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .rec_i       (trace_i[c]),
         .ev_valid_o  (ev_valid[c]),
         .ev_o        (ev[c]),
         .exit_o      (exit_strobe[c]),
         .exit_code_o (exit_code[c])
      );

      event_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_fifo (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .push_i      (ev_valid[c]),
         .data_i      (ev[c]),
         .pop_i       (fifo_pop[c]),
         .not_empty_o (fifo_not_empty[c]),
         .head_o      (fifo_head[c]),
         .overflow_o  (overflow_o[c])
      );
   end

   // Merge into one stream
   event_arbiter #(
      .NUM_CORES (NUM_CORES)
   ) u_arbiter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (fifo_not_empty),
      .head_i        (fifo_head),
      .pop_o         (fifo_pop),
      .event_valid_o (event_valid_o),
      .event_o       (event_o)
   );

   // Exit tracking across all cores
   termination_collector #(
      .NUM_CORES (NUM_CORES)
   ) u_collector (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .exit_i       (exit_strobe),
      .code_i       (exit_code),
      .exited_o     (exited_o),
      .exit_codes_o (exit_codes_o),
      .all_done_o   (all_done_o)
   );

endmodule

/* src/termination_collector.sv */
module termination_collector #(
   parameter int NUM_CORES = 4
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [NUM_CORES-1:0]       exit_i,
   input  logic [NUM_CORES-1:0][31:0] code_i,
   output logic [NUM_CORES-1:0]       exited_o,
   output logic [NUM_CORES-1:0][31:0] exit_codes_o,
   output logic                       all_done_o
);

   logic [NUM_CORES-1:0]       exited_q;
   logic [NUM_CORES-1:0]       exited_d;
   logic [NUM_CORES-1:0][31:0] codes_q;
   logic                       all_done_q;

   // Exit set including this cycle's strobes
   assign exited_d = exited_q | exit_i;

   // Only the first exit of each core is latched
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exited_q <= '0;
         codes_q  <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (exit_i[c] && !exited_q[c]) begin
               exited_q[c] <= 1'b1;
               codes_q[c]  <= code_i[c];
            end
         end
      end
   end

   // Looks at the next exit set so it rises together with the last bit
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         all_done_q <= 1'b0;
      end else begin
         all_done_q <= &exited_d;
      end
   end

   assign exited_o     = exited_q;
   assign exit_codes_o = codes_q;
   assign all_done_o   = all_done_q;

endmodule

/* src/event_arbiter.sv */
module event_arbiter #(
   parameter int NUM_CORES = 4
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic [NUM_CORES-1:0]                  req_i,
   input  trace_pkg::mon_event_t [NUM_CORES-1:0] head_i,
   output logic [NUM_CORES-1:0]                  pop_o,
   output logic                                  event_valid_o,
   output trace_pkg::mon_event_t                 event_o
);

   localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

   // Index of the most recent winner
   logic [IDX_W-1:0] last_q;
   logic [IDX_W-1:0] grant_idx;
   logic             grant_any;

   // Search starts one past the last winner and wraps
   always_comb begin
      int unsigned cand;
      grant_any = 1'b0;
      grant_idx = last_q;
      for (int i = 1; i <= NUM_CORES; i++) begin
         cand = (int'(last_q) + i) % NUM_CORES;
         if (!grant_any && req_i[cand]) begin
            grant_any = 1'b1;
            grant_idx = IDX_W'(cand);
         end
      end
   end

   // Pop goes to the winner only
   always_comb begin
      pop_o = '0;
      if (grant_any) begin
         pop_o[grant_idx] = 1'b1;
      end
   end

   // Pointer starts at the top so core 0 wins first after reset
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_q        <= IDX_W'(NUM_CORES - 1);
         event_valid_o <= 1'b0;
      end else begin
         event_valid_o <= grant_any;
         if (grant_any) begin
            last_q <= grant_idx;
         end
      end
   end

   // Output word holds the popped head
   always_ff @(posedge clk_i) begin
      if (grant_any) begin
         event_o <= head_i[grant_idx];
      end
   end

   // At most one FIFO is popped per cycle
   a_pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(pop_o));

endmodule

/* src/event_fifo.sv */
module event_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  push_i,
   input  trace_pkg::mon_event_t data_i,
   input  logic                  pop_i,
   output logic                  not_empty_o,
   output trace_pkg::mon_event_t head_o,
   output logic                  overflow_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

   // Circular storage
   trace_pkg::mon_event_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic             full;
   logic             wr_en;
   logic             overflow_q;

   assign full  = count_q == FULL_COUNT;
   // Pushes into a full buffer are lost
   assign wr_en = push_i && !full;

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   // Pointers wrap at the last slot
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
         end
      end
   end

   // Push and pop together leave the fill level unchanged
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else begin
         case ({wr_en, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Sticky until reset
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         overflow_q <= 1'b0;
      end else if (push_i && full) begin
         overflow_q <= 1'b1;
      end
   end

   assign not_empty_o = count_q != '0;
   assign head_o      = mem[rd_ptr_q];
   assign overflow_o  = overflow_q;

   // The arbiter only pops a buffer that holds an entry
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> not_empty_o);

endmodule

/* src/core_trace_monitor.sv */
module core_trace_monitor #(
   parameter int CORE_ID = 0
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  trace_pkg::trace_rec_t rec_i,
   output logic                  ev_valid_o,
   output trace_pkg::mon_event_t ev_o,
   output logic                  exit_o,
   output logic [31:0]           exit_code_o
);

   // Register index that carries the argument of a no-operation call
   localparam logic [4:0] R3_IDX = 5'd3;

   // Core number as it appears in the event
   localparam logic [trace_pkg::CORE_ID_W-1:0] CORE_NUM = CORE_ID[trace_pkg::CORE_ID_W-1:0];

   // Shadow copy of r3
   logic [31:0] r3_q;

   // Instruction word in no-operation layout
   trace_pkg::nop_insn_t nop;

   logic                   ev_hit;
   trace_pkg::event_kind_e ev_kind;
   trace_pkg::mon_event_t  ev_q;

   assign nop = trace_pkg::nop_insn_t'(rec_i.insn);

   // Decode the special no-operations
   always_comb begin
      ev_hit  = 1'b0;
      ev_kind = trace_pkg::EV_REPORT;
      if (rec_i.valid && nop.opcode == trace_pkg::NOP_OPCODE && nop.reserved == 8'h00) begin
         case (nop.k)
            trace_pkg::NOP_K_EXIT: begin
               ev_hit  = 1'b1;
               ev_kind = trace_pkg::EV_EXIT;
            end
            trace_pkg::NOP_K_REPORT: begin
               ev_hit  = 1'b1;
               ev_kind = trace_pkg::EV_REPORT;
            end
            trace_pkg::NOP_K_PUTC: begin
               ev_hit  = 1'b1;
               ev_kind = trace_pkg::EV_PUTC;
            end
            // Other immediates are plain no-operations
            default: ev_hit = 1'b0;
         endcase
      end
   end

   // Shadow follows every retired write to r3
   // The event below samples the value before this edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r3_q <= '0;
      end else if (rec_i.valid && rec_i.wben && rec_i.wbreg == R3_IDX) begin
         r3_q <= rec_i.wbdata;
      end
   end

   // One-cycle strobes towards FIFO and collector
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ev_valid_o <= 1'b0;
         exit_o     <= 1'b0;
      end else begin
         ev_valid_o <= ev_hit;
         exit_o     <= ev_hit && ev_kind == trace_pkg::EV_EXIT;
      end
   end

   // Event payload is loaded only on a hit
   always_ff @(posedge clk_i) begin
      if (ev_hit) begin
         ev_q.core  <= CORE_NUM;
         ev_q.kind  <= ev_kind;
         ev_q.pc    <= rec_i.pc;
         ev_q.value <= r3_q;
      end
   end

   assign ev_o        = ev_q;
   // Exit code is the r3 value of the exit event
   assign exit_code_o = ev_q.value;

   // An exit pulse always travels with its own event strobe
   a_exit_has_event: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exit_o |-> ev_valid_o);

endmodule

/* src/trace_pkg.sv */
package trace_pkg;

   // Width of the core number carried in each event
   localparam int CORE_ID_W = 4;

   // One retired instruction as seen at writeback
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_rec_t;

   // Instruction word viewed in the no-operation format
   typedef struct packed {
      logic [7:0]  opcode;
      logic [7:0]  reserved;
      logic [15:0] k;
   } nop_insn_t;

   // Major opcode byte of l.nop
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // Immediates that software uses to talk to the simulation
   localparam logic [15:0] NOP_K_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_K_REPORT = 16'h0002;
   localparam logic [15:0] NOP_K_PUTC   = 16'h0004;

   typedef enum logic [1:0] {
      EV_EXIT   = 2'd0,
      EV_REPORT = 2'd1,
      EV_PUTC   = 2'd2
   } event_kind_e;

   // Monitor event of 70 bits
   typedef struct packed {
      logic [CORE_ID_W-1:0] core;
      event_kind_e          kind;
      logic [31:0]          pc;
      logic [31:0]          value;
   } mon_event_t;

endpackage
